/* mem_sched_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Memory scheduler sizes
// Lane, channel, width and queue constants
// ~~~~~~~~~~~~~~~~~~~~

`ifndef MEM_SCHED_MACROS_SVH
`define MEM_SCHED_MACROS_SVH

// Core side lanes and memory side channels
`define MS_CORE_REQS     4
`define MS_MEM_CHANNELS  2
`define MS_MEM_BATCHES   2
`define MS_BATCH_BITS    1

// Word geometry, line size equals word size
`define MS_WORD_SIZE     4
`define MS_WORD_WIDTH    32
`define MS_ADDR_WIDTH    30

`define MS_TAG_WIDTH     8

// Queue depth doubles as number of read slots
`define MS_QUEUE_SIZE    4
`define MS_SLOT_BITS     2

`endif

/* mem_sched_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Memory scheduler types
// Request, response and tag structs
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

package mem_sched_pkg;

    typedef struct packed {
        logic                                              rw;
        logic [`MS_CORE_REQS-1:0]                          mask;
        logic [`MS_CORE_REQS-1:0][`MS_WORD_SIZE-1:0]       byteen;
        logic [`MS_CORE_REQS-1:0][`MS_ADDR_WIDTH-1:0]      addr;
        logic [`MS_CORE_REQS-1:0][`MS_WORD_WIDTH-1:0]      data;
        logic [`MS_TAG_WIDTH-1:0]                          tag;
    } core_req_t;

    typedef struct packed {
        logic [`MS_CORE_REQS-1:0]                          mask;
        logic [`MS_CORE_REQS-1:0][`MS_WORD_WIDTH-1:0]      data;
        logic [`MS_TAG_WIDTH-1:0]                          tag;
    } core_rsp_t;

    typedef struct packed {
        logic [`MS_SLOT_BITS-1:0]                          slot;
        logic [`MS_BATCH_BITS-1:0]                         batch;
    } mem_tag_t;

    typedef struct packed {
        logic                                              rw;
        logic [`MS_MEM_CHANNELS-1:0]                       mask;
        logic [`MS_MEM_CHANNELS-1:0][`MS_WORD_SIZE-1:0]    byteen;
        logic [`MS_MEM_CHANNELS-1:0][`MS_ADDR_WIDTH-1:0]   addr;
        logic [`MS_MEM_CHANNELS-1:0][`MS_WORD_WIDTH-1:0]   data;
        mem_tag_t                                          tag;
    } mem_req_t;

    typedef struct packed {
        logic [`MS_MEM_CHANNELS-1:0]                       mask;
        logic [`MS_MEM_CHANNELS-1:0][`MS_WORD_WIDTH-1:0]   data;
        mem_tag_t                                          tag;
    } mem_rsp_t;

    // Core tag swapped for the read slot index
    typedef struct packed {
        logic                                              rw;
        logic [`MS_CORE_REQS-1:0]                          mask;
        logic [`MS_CORE_REQS-1:0][`MS_WORD_SIZE-1:0]       byteen;
        logic [`MS_CORE_REQS-1:0][`MS_ADDR_WIDTH-1:0]      addr;
        logic [`MS_CORE_REQS-1:0][`MS_WORD_WIDTH-1:0]      data;
        logic [`MS_SLOT_BITS-1:0]                          slot;
    } queue_entry_t;

endpackage

/* mem_sched_req_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Request queue
// FIFO of core requests, reads gated on a free slot
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module mem_sched_req_queue (
    input  logic                           clk,
    input  logic                           reset,
    input  mem_sched_pkg::core_req_t       core_req,
    input  logic                           core_req_valid,
    output logic                           core_req_ready,
    input  logic                           slot_full,
    input  logic [`MS_SLOT_BITS-1:0]       free_slot,
    output logic                           alloc,
    output mem_sched_pkg::queue_entry_t    head,
    output logic                           head_valid,
    input  logic                           head_ready
);

    mem_sched_pkg::queue_entry_t entries [`MS_QUEUE_SIZE];
    mem_sched_pkg::queue_entry_t entry_in;

    logic [`MS_SLOT_BITS-1:0] wr_ptr;
    logic [`MS_SLOT_BITS-1:0] rd_ptr;
    logic [`MS_SLOT_BITS:0]   count;
    logic                     queue_full;
    logic                     push;
    logic                     pop;

    assign queue_full = (count == (`MS_SLOT_BITS+1)'(`MS_QUEUE_SIZE));

    // Writes need room only, reads also need a slot
    assign core_req_ready = ~queue_full && (core_req.rw || ~slot_full);
    assign push  = core_req_valid && core_req_ready;
    assign alloc = push && ~core_req.rw;

    assign head_valid = (count != '0);
    assign pop  = head_valid && head_ready;
    assign head = entries[rd_ptr];

    always_comb begin
        entry_in.rw     = core_req.rw;
        entry_in.mask   = core_req.mask;
        entry_in.byteen = core_req.byteen;
        entry_in.addr   = core_req.addr;
        entry_in.data   = core_req.data;
        entry_in.slot   = free_slot;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* mem_sched_index_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Read slot allocator
// Keeps core tag and original mask per pending read
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module mem_sched_index_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alloc,
    input  logic [`MS_TAG_WIDTH-1:0]    core_tag,
    input  logic [`MS_CORE_REQS-1:0]    core_mask,
    output logic [`MS_SLOT_BITS-1:0]    free_slot,
    output logic                        full,
    input  logic                        release_en,
    input  logic [`MS_SLOT_BITS-1:0]    release_slot,
    input  logic [`MS_SLOT_BITS-1:0]    rd_slot,
    output logic [`MS_TAG_WIDTH-1:0]    rd_tag,
    output logic [`MS_CORE_REQS-1:0]    rd_mask
);

    logic [`MS_QUEUE_SIZE-1:0] free_bits;
    logic [`MS_TAG_WIDTH-1:0]  tag_store  [`MS_QUEUE_SIZE];
    logic [`MS_CORE_REQS-1:0]  mask_store [`MS_QUEUE_SIZE];

    assign full = ~(|free_bits);

    // Lowest free slot wins
    always_comb begin
        free_slot = '0;
        for (int i = `MS_QUEUE_SIZE - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                free_slot = `MS_SLOT_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            free_bits <= '1;
        end else begin
            // Released slot is busy, so it never matches the allocated one
            if (release_en) begin
                free_bits[release_slot] <= 1'b1;
            end
            if (alloc) begin
                free_bits[free_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_store[free_slot]  <= core_tag;
            mask_store[free_slot] <= core_mask;
        end
    end

    assign rd_tag  = tag_store[rd_slot];
    assign rd_mask = mask_store[rd_slot];

endmodule

/* mem_sched_batcher.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Request batcher
// Slices queue head into memory-channel batches
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module mem_sched_batcher (
    input  logic                           clk,
    input  logic                           reset,
    input  mem_sched_pkg::queue_entry_t    head,
    input  logic                           head_valid,
    output logic                           head_ready,
    output mem_sched_pkg::mem_req_t        mem_req,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready
);

    logic [`MS_BATCH_BITS-1:0] batch_idx;
    logic [`MS_BATCH_BITS-1:0] last_batch;
    logic                      batch_empty;
    logic                      advance;

    // Highest batch holding any mask bit
    always_comb begin
        last_batch = '0;
        for (int b = 0; b < `MS_MEM_BATCHES; b++) begin
            if (|head.mask[b * `MS_MEM_CHANNELS +: `MS_MEM_CHANNELS]) begin
                last_batch = `MS_BATCH_BITS'(b);
            end
        end
    end

    // Lane = batch * channels + channel
    always_comb begin
        mem_req.rw        = head.rw;
        mem_req.tag.slot  = head.slot;
        mem_req.tag.batch = batch_idx;
        for (int c = 0; c < `MS_MEM_CHANNELS; c++) begin
            mem_req.mask[c]   = head.mask[batch_idx * `MS_MEM_CHANNELS + c];
            mem_req.byteen[c] = head.byteen[batch_idx * `MS_MEM_CHANNELS + c];
            mem_req.addr[c]   = head.addr[batch_idx * `MS_MEM_CHANNELS + c];
            mem_req.data[c]   = head.data[batch_idx * `MS_MEM_CHANNELS + c];
        end
    end

    assign batch_empty   = ~(|mem_req.mask);
    assign mem_req_valid = head_valid && ~batch_empty;

    // Empty batches step on without waiting for memory
    assign advance    = head_valid && (mem_req_ready || batch_empty);
    assign head_ready = advance && (batch_idx == last_batch);

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx <= '0;
        end else if (advance) begin
            if (head_ready) begin
                batch_idx <= '0;
            end else begin
                batch_idx <= batch_idx + 1'b1;
            end
        end
    end

endmodule

/* mem_sched_rsp_merge.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Response merge
// Gathers fragments per slot into one core response
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module mem_sched_rsp_merge (
    input  logic                        clk,
    input  logic                        reset,
    input  mem_sched_pkg::mem_rsp_t     mem_rsp,
    input  logic                        mem_rsp_valid,
    output logic                        mem_rsp_ready,
    input  logic                        alloc,
    input  logic [`MS_SLOT_BITS-1:0]    alloc_slot,
    input  logic [`MS_CORE_REQS-1:0]    alloc_mask,
    input  logic [`MS_TAG_WIDTH-1:0]    rd_tag,
    input  logic [`MS_CORE_REQS-1:0]    rd_mask,
    output logic [`MS_SLOT_BITS-1:0]    rd_slot,
    output logic                        release_en,
    output mem_sched_pkg::core_rsp_t    core_rsp,
    output logic                        core_rsp_valid,
    input  logic                        core_rsp_ready
);

    logic [`MS_CORE_REQS-1:0] rem_mask [`MS_QUEUE_SIZE];
    logic [`MS_CORE_REQS-1:0][`MS_WORD_WIDTH-1:0] data_store [`MS_QUEUE_SIZE];

    logic [`MS_CORE_REQS-1:0] rem_next;
    logic [`MS_CORE_REQS-1:0][`MS_WORD_WIDTH-1:0] store_next;
    logic                     complete;
    logic                     mem_rsp_fire;

    assign rd_slot = mem_rsp.tag.slot;

    // Clear arriving lanes and merge their data
    always_comb begin
        rem_next   = rem_mask[rd_slot];
        store_next = data_store[rd_slot];
        for (int c = 0; c < `MS_MEM_CHANNELS; c++) begin
            if (mem_rsp.mask[c]) begin
                rem_next[mem_rsp.tag.batch * `MS_MEM_CHANNELS + c]   = 1'b0;
                store_next[mem_rsp.tag.batch * `MS_MEM_CHANNELS + c] = mem_rsp.data[c];
            end
        end
    end

    assign complete = ~(|rem_next);

    // Last fragment waits on the core side
    assign mem_rsp_ready  = core_rsp_ready || ~complete;
    assign mem_rsp_fire   = mem_rsp_valid && mem_rsp_ready;
    assign core_rsp_valid = mem_rsp_valid && complete;
    assign release_en     = core_rsp_valid && core_rsp_ready;

    assign core_rsp.mask = rd_mask;
    assign core_rsp.data = store_next;
    assign core_rsp.tag  = rd_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MS_QUEUE_SIZE; i++) begin
                rem_mask[i] <= '0;
            end
        end else begin
            // alloc_slot is free, rd_slot is busy
            if (alloc) begin
                rem_mask[alloc_slot] <= alloc_mask;
            end
            if (mem_rsp_fire) begin
                rem_mask[rd_slot] <= rem_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_fire) begin
            data_store[rd_slot] <= store_next;
        end
    end

endmodule

/* mem_sched.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Memory request scheduler
// Queue, slot buffer, batcher and response merge
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module mem_sched (
    input  logic                           clk,
    input  logic                           reset,
    input  mem_sched_pkg::core_req_t       core_req,
    input  logic                           core_req_valid,
    output logic                           core_req_ready,
    output mem_sched_pkg::core_rsp_t       core_rsp,
    output logic                           core_rsp_valid,
    input  logic                           core_rsp_ready,
    output mem_sched_pkg::mem_req_t        mem_req,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    input  mem_sched_pkg::mem_rsp_t        mem_rsp,
    input  logic                           mem_rsp_valid,
    output logic                           mem_rsp_ready
);

    logic                        slot_full;
    logic [`MS_SLOT_BITS-1:0]    free_slot;
    logic                        alloc;
    logic                        head_valid;
    logic                        head_ready;
    logic [`MS_SLOT_BITS-1:0]    rd_slot;
    logic [`MS_TAG_WIDTH-1:0]    rd_tag;
    logic [`MS_CORE_REQS-1:0]    rd_mask;
    logic                        release_en;

    mem_sched_pkg::queue_entry_t head;

    mem_sched_req_queue u_req_queue (
        .clk            (clk),
        .reset          (reset),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .slot_full      (slot_full),
        .free_slot      (free_slot),
        .alloc          (alloc),
        .head           (head),
        .head_valid     (head_valid),
        .head_ready     (head_ready)
    );

    // Released slot is the one the current response reads
    mem_sched_index_buffer u_index_buffer (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .core_tag     (core_req.tag),
        .core_mask    (core_req.mask),
        .free_slot    (free_slot),
        .full         (slot_full),
        .release_en   (release_en),
        .release_slot (rd_slot),
        .rd_slot      (rd_slot),
        .rd_tag       (rd_tag),
        .rd_mask      (rd_mask)
    );

    mem_sched_batcher u_batcher (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .head_valid    (head_valid),
        .head_ready    (head_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready)
    );

    mem_sched_rsp_merge u_rsp_merge (
        .clk            (clk),
        .reset          (reset),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .alloc          (alloc),
        .alloc_slot     (free_slot),
        .alloc_mask     (core_req.mask),
        .rd_tag         (rd_tag),
        .rd_mask        (rd_mask),
        .rd_slot        (rd_slot),
        .release_en     (release_en),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

/* tb_mem_sched_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Scheduler checker
// Shadow memory and core response comparison
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module tb_mem_sched_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [8*16-1:0]             test_name,
    input  mem_sched_pkg::core_req_t    core_req,
    input  logic                        core_req_valid,
    input  logic                        core_req_ready,
    input  mem_sched_pkg::core_rsp_t    core_rsp,
    input  logic                        core_rsp_valid,
    input  logic                        core_rsp_ready,
    input  mem_sched_pkg::mem_req_t     mem_req,
    input  logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    output int                          data_errors,
    output int                          protocol_errors,
    output int                          outstanding
);

    logic [`MS_WORD_WIDTH-1:0]   shadow [16];
    mem_sched_pkg::core_rsp_t    expected [256];
    logic [8*16-1:0]             exp_name [256];
    logic [255:0]                pending;
    logic [`MS_MEM_CHANNELS-1:0] chan_masks [$];
    int                          reads_in_flight;

    // Masked lanes read the shadow word as of acceptance
    function automatic mem_sched_pkg::core_rsp_t expected_rsp(
        input mem_sched_pkg::core_req_t req
    );
        mem_sched_pkg::core_rsp_t rsp;
        rsp = '0;
        rsp.mask = req.mask;
        rsp.tag  = req.tag;
        for (int i = 0; i < `MS_CORE_REQS; i++) begin
            if (req.mask[i]) begin
                rsp.data[i] = shadow[req.addr[i][3:0]];
            end
        end
        return rsp;
    endfunction

    initial begin
        // Same fill as the memory model
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 32'h1357_9bdf ^ (i * 32'h0101_0101);
        end
        pending         = '0;
        reads_in_flight = 0;
        data_errors     = 0;
        protocol_errors = 0;
        outstanding     = 0;
    end

    always @(posedge clk) begin
        mem_sched_pkg::core_rsp_t    want;
        logic [`MS_MEM_CHANNELS-1:0] want_mask;
        if (!reset) begin
            if (mem_req_valid && mem_req.mask == '0) begin
                protocol_errors++;
                $display("Memory request issued with an empty channel mask");
            end
            if (mem_req_valid && mem_req_ready) begin
                if (chan_masks.size() == 0) begin
                    protocol_errors++;
                    $display("Memory request issued when none was expected");
                end else begin
                    want_mask = chan_masks.pop_front();
                    if (mem_req.mask != want_mask) begin
                        data_errors++;
                        $display("Error %0s channel mask: expected %b, actual %b",
                                 test_name, want_mask, mem_req.mask);
                    end
                end
            end
            if (core_req_valid && core_req_ready) begin
                // One memory request per non-empty batch, in order
                for (int b = 0; b < `MS_MEM_BATCHES; b++) begin
                    if (|core_req.mask[b*`MS_MEM_CHANNELS +: `MS_MEM_CHANNELS]) begin
                        chan_masks.push_back(
                            core_req.mask[b*`MS_MEM_CHANNELS +: `MS_MEM_CHANNELS]);
                    end
                end
                if (core_req.rw) begin
                    for (int i = 0; i < `MS_CORE_REQS; i++) begin
                        for (int j = 0; j < `MS_WORD_SIZE; j++) begin
                            if (core_req.mask[i] && core_req.byteen[i][j]) begin
                                shadow[core_req.addr[i][3:0]][j*8 +: 8] =
                                    core_req.data[i][j*8 +: 8];
                            end
                        end
                    end
                end else begin
                    if (reads_in_flight >= `MS_QUEUE_SIZE) begin
                        protocol_errors++;
                        $display("Read accepted while every slot was busy");
                    end
                    expected[core_req.tag] = expected_rsp(core_req);
                    exp_name[core_req.tag] = test_name;
                    pending[core_req.tag]  = 1'b1;
                    reads_in_flight++;
                end
            end
            if (core_rsp_valid && core_rsp_ready) begin
                want = expected[core_rsp.tag];
                if (!pending[core_rsp.tag]) begin
                    protocol_errors++;
                    $display("Core response with tag %0h has no pending read", core_rsp.tag);
                end else begin
                    if (core_rsp.mask != want.mask) begin
                        data_errors++;
                        $display("Error %0s tag %0h mask: expected %b, actual %b",
                                 exp_name[core_rsp.tag], core_rsp.tag, want.mask,
                                 core_rsp.mask);
                    end
                    for (int i = 0; i < `MS_CORE_REQS; i++) begin
                        if (want.mask[i] && core_rsp.data[i] !== want.data[i]) begin
                            data_errors++;
                            $display("Error %0s tag %0h lane %0d: expected %h, actual %h",
                                     exp_name[core_rsp.tag], core_rsp.tag, i,
                                     want.data[i], core_rsp.data[i]);
                        end
                    end
                    pending[core_rsp.tag] = 1'b0;
                    reads_in_flight--;
                end
            end
            outstanding = reads_in_flight + chan_masks.size();
        end
    end

endmodule

/* tb_mem_sched.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Scheduler testbench
// Directed and random traffic against a memory model
// ~~~~~~~~~~~~~~~~~~~~

`include "mem_sched_macros.svh"

module tb_mem_sched;

    localparam int WAIT_LIMIT = 2000;

    logic                        clk;
    logic                        reset;
    mem_sched_pkg::core_req_t    core_req;
    logic                        core_req_valid;
    logic                        core_req_ready;
    mem_sched_pkg::core_rsp_t    core_rsp;
    logic                        core_rsp_valid;
    logic                        core_rsp_ready;
    mem_sched_pkg::mem_req_t     mem_req;
    logic                        mem_req_valid;
    logic                        mem_req_ready;
    mem_sched_pkg::mem_rsp_t     mem_rsp;
    logic                        mem_rsp_valid;
    logic                        mem_rsp_ready;

    logic [8*16-1:0]             test_name;
    logic                        rsp_hold;
    integer                      seed;
    int                          next_tag;
    int                          data_errors;
    int                          protocol_errors;
    int                          outstanding;
    int                          timeout_errors;
    logic [`MS_WORD_WIDTH-1:0]   mem_words [16];
    mem_sched_pkg::mem_rsp_t     frags [$];

    mem_sched u_mem_sched (.*);

    tb_mem_sched_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory model, read data captured at request and answered in random order
    always @(posedge clk) begin
        mem_sched_pkg::mem_rsp_t frag;
        int                      pick;
        if (reset) begin
            mem_rsp_valid  <= 1'b0;
            mem_req_ready  <= 1'b0;
            core_rsp_ready <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                frag      = '0;
                frag.mask = mem_req.mask;
                frag.tag  = mem_req.tag;
                for (int c = 0; c < `MS_MEM_CHANNELS; c++) begin
                    for (int j = 0; j < `MS_WORD_SIZE; j++) begin
                        if (mem_req.mask[c] && mem_req.rw && mem_req.byteen[c][j]) begin
                            mem_words[mem_req.addr[c][3:0]][j*8 +: 8] = mem_req.data[c][j*8 +: 8];
                        end
                    end
                    frag.data[c] = mem_words[mem_req.addr[c][3:0]];
                end
                if (!mem_req.rw) begin
                    frags.push_back(frag);
                end
            end
            if (!mem_rsp_valid || mem_rsp_ready) begin
                if (frags.size() != 0 && $random(seed) % 2 != 0) begin
                    pick = $unsigned($random(seed)) % frags.size();
                    mem_rsp       <= frags[pick];
                    mem_rsp_valid <= 1'b1;
                    frags.delete(pick);
                end else begin
                    mem_rsp_valid <= 1'b0;
                end
            end
            mem_req_ready  <= ($random(seed) % 3) != 0;
            core_rsp_ready <= !rsp_hold && (($random(seed) % 3) != 0);
        end
    end

    task automatic send_req(input mem_sched_pkg::core_req_t req);
        int waited;
        waited = 0;
        core_req       <= req;
        core_req_valid <= 1'b1;
        @(posedge clk);
        while (!core_req_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!core_req_ready) begin
            timeout_errors++;
            $display("Timeout: a core request in %0s was never accepted", test_name);
        end
        core_req_valid <= 1'b0;
    endtask

    // Negative base gives random addresses in the 16-word window
    task automatic issue(input logic rw, input logic [`MS_CORE_REQS-1:0] mask,
                         input logic [`MS_WORD_SIZE-1:0] byteen, input int base);
        mem_sched_pkg::core_req_t req;
        req      = '0;
        req.rw   = rw;
        req.mask = mask;
        for (int i = 0; i < `MS_CORE_REQS; i++) begin
            req.byteen[i] = byteen;
            req.addr[i]   = (base < 0) ? `MS_ADDR_WIDTH'($unsigned($random(seed)) % 16)
                                       : `MS_ADDR_WIDTH'(base + i);
            req.data[i]   = $random(seed);
        end
        req.tag = next_tag[`MS_TAG_WIDTH-1:0];
        next_tag++;
        send_req(req);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (outstanding != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (outstanding != 0) begin
            timeout_errors++;
            $display("Timeout: %0d reads or memory requests never completed", outstanding);
        end
        @(posedge clk);
    endtask

    initial begin
        logic [`MS_CORE_REQS-1:0] mask;
        seed           = 32'hefcb919f;
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        core_rsp_ready = 1'b0;
        mem_req_ready  = 1'b0;
        mem_rsp        = '0;
        mem_rsp_valid  = 1'b0;
        rsp_hold       = 1'b0;
        next_tag       = 0;
        timeout_errors = 0;
        test_name      = "reset";
        for (int i = 0; i < 16; i++) begin
            mem_words[i] = 32'h1357_9bdf ^ (i * 32'h0101_0101);
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        test_name <= "write_read";
        issue(1'b1, 4'hf, 4'hf, 0);
        issue(1'b0, 4'hf, 4'hf, 0);

        test_name <= "byte_enable";
        issue(1'b1, 4'hf, 4'hf, 4);
        issue(1'b1, 4'hf, 4'b0101, 4);
        issue(1'b1, 4'b0110, 4'b1000, 4);
        issue(1'b0, 4'hf, 4'hf, 4);

        test_name <= "empty_batch";
        issue(1'b0, 4'b0011, 4'hf, 8);
        issue(1'b0, 4'b1100, 4'hf, 8);
        issue(1'b0, 4'b1001, 4'hf, 8);

        // Mixed traffic keeps several reads in flight
        test_name <= "out_of_order";
        for (int n = 0; n < 200; n++) begin
            mask = `MS_CORE_REQS'($random(seed));
            issue(1'($random(seed) % 3 == 0), (mask == 0) ? 4'h1 : mask,
                  4'($random(seed)), -1);
        end
        wait_idle();

        // Fifth read has to wait for a released slot
        test_name <= "back_pressure";
        rsp_hold  <= 1'b1;
        repeat (`MS_QUEUE_SIZE) issue(1'b0, 4'hf, 4'hf, -1);
        fork
            issue(1'b0, 4'hf, 4'hf, -1);
            begin
                repeat (40) @(posedge clk);
                rsp_hold <= 1'b0;
            end
        join
        wait_idle();

        @(negedge clk);
        $display("Errors: %0d data, %0d protocol, %0d timeout",
                 data_errors, protocol_errors, timeout_errors);
        if (data_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
mem_sched_pkg.sv
mem_sched_req_queue.sv
mem_sched_index_buffer.sv
mem_sched_batcher.sv
mem_sched_rsp_merge.sv
mem_sched.sv
tb_mem_sched_checker.sv
tb_mem_sched.sv

/* Bender.yml */
package:
  name: mem_sched

export_include_dirs:
  - .

sources:
  - mem_sched_pkg.sv
  - mem_sched_req_queue.sv
  - mem_sched_index_buffer.sv
  - mem_sched_batcher.sv
  - mem_sched_rsp_merge.sv
  - mem_sched.sv
  - target: test
    files:
      - tb_mem_sched_checker.sv
      - tb_mem_sched.sv
